//--- rtl/sd_pkg.sv
// sd data bus shared types
package sd_pkg;

	typedef logic [7:0]  byte_t;   // one data byte
	typedef logic [1:0]  pair_t;   // bit 1 is line 1, bit 0 is line 0
	typedef logic [15:0] crc_t;    // crc-16 remainder

	// what a line drives or checks in the current bit time
	typedef enum logic [2:0]
	{
		PH_IDLE,
		PH_START,
		PH_DATA,
		PH_CRC,
		PH_END
	} line_phase_t;

	// block sequencer states
	typedef enum logic [2:0]
	{
		S_IDLE,
		S_TX,
		S_RX_WAIT,
		S_RX
	} seq_state_t;

endpackage

//--- rtl/sd_crc16.sv
// serial crc-16 generator
module sd_crc16
(
	input  logic clk,
	input  logic rst,
	input  logic clr,
	input  logic gen_en,
	input  logic out_en,
	input  logic din,
	output logic dout
);
	import sd_pkg::*;

	localparam crc_t POLY = 16'h1021;   // x^16 + x^12 + x^5 + 1

	crc_t rem;
	logic fb;

	assign fb   = rem[15] ^ din;
	assign dout = rem[15];              // msb goes out first

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			rem <= '0;
		else if (clr)
			rem <= '0;
		else if (gen_en)
			rem <= {rem[14:0], 1'b0} ^ (fb ? POLY : crc_t'(0));
		else if (out_en)
			rem <= {rem[14:0], 1'b0};   // zero fill behind the shifted bits
	end

	// generating and shifting out are separate phases of a block
	a_gen_out_excl : assert property (@(posedge clk) disable iff (rst)
		!(gen_en && out_en));

endmodule

//--- rtl/sd_dat_line.sv
// single dat line driver and checker
module sd_dat_line
(
	input  logic                clk,
	input  logic                rst,
	input  sd_pkg::line_phase_t phase,
	input  logic                tx,
	input  logic                rx_mode,
	input  logic                crc_clr,
	input  logic                dat_in,
	output logic                dat_out,
	output logic                dat_oe,
	output logic                rx_bit,
	output logic                error
);
	import sd_pkg::*;

	logic crc_din;
	logic crc_dout;
	logic frame_bit;
	logic crc_bad;
	logic end_bad;

	// in receive the crc runs over what is sampled from the pin
	assign crc_din = rx_mode ? dat_in : tx;

	assign crc_bad = rx_mode && (phase == PH_CRC) && (dat_in != crc_dout);
	assign end_bad = rx_mode && (phase == PH_END) && !dat_in;

	always_comb
	begin
		case (phase)
			PH_START: frame_bit = 1'b0;
			PH_DATA:  frame_bit = tx;
			PH_CRC:   frame_bit = crc_dout;
			default:  frame_bit = 1'b1;   // end bit and idle level
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// output register

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			dat_out <= 1'b1;
			dat_oe  <= 1'b0;
		end
		else
		begin
			dat_out <= frame_bit;
			dat_oe  <= (phase != PH_IDLE) && !rx_mode;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rx_mode)
			rx_bit <= dat_in;
	end

	// crc mismatch or bad end bit, held until the next block
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			error <= 1'b0;
		else if (crc_clr)
			error <= 1'b0;
		else if (crc_bad || end_bad)
			error <= 1'b1;
	end

	sd_crc16 i_crc
	(
		.clk    (clk),
		.rst    (rst),
		.clr    (crc_clr),
		.gen_en (phase == PH_DATA),
		.out_en (phase == PH_CRC),
		.din    (crc_din),
		.dout   (crc_dout)
	);

	// the sequencer never turns the driver on during a receive
	a_no_oe_in_rx : assert property (@(posedge clk) disable iff (rst)
		$rose(dat_oe) |-> !rx_mode);

endmodule

//--- rtl/sd_dat_sequencer.sv
// dat block sequencer
module sd_dat_sequencer
#(
	parameter int BLOCK_BYTES = 8
)
(
	input  logic                clk,
	input  logic                rst,
	input  logic                tx_start,
	input  logic                rx_start,
	input  sd_pkg::pair_t       dat_in,
	input  logic                rd_room,
	output sd_pkg::line_phase_t phase,
	output logic                rx_mode,
	output logic                crc_clr,
	output logic                tx_take,
	output logic                rx_shift,
	output logic                tx_done,
	output logic                rx_done
);
	import sd_pkg::*;

	localparam int NDATA = 4 * BLOCK_BYTES;   // bit times of data per line
	localparam int LAST  = NDATA + 16;        // end bit position
	localparam int CNT_W = $clog2(LAST + 1);

	seq_state_t       state;
	logic [CNT_W-1:0] cnt;
	logic             start_seen;
	logic             tx_end_d;

	// card start bit, only looked for once the reader can take a whole block
	assign start_seen = rd_room && (dat_in == 2'b00);

	//////////////////////////////////////////////////////////////////////
	// phase decode, one bit time ahead of the pin in transmit

	always_comb
	begin
		phase = PH_IDLE;
		case (state)
			S_IDLE:
				if (tx_start)
					phase = PH_START;
			S_RX_WAIT:
				if (start_seen)
					phase = PH_START;
			S_TX, S_RX:
			begin
				if (int'(cnt) < NDATA)
					phase = PH_DATA;
				else if (int'(cnt) < LAST)
					phase = PH_CRC;
				else
					phase = PH_END;
			end
			default:
				phase = PH_IDLE;
		endcase
	end

	assign rx_mode  = (state == S_RX_WAIT) || (state == S_RX);
	assign crc_clr  = (state == S_IDLE) && (tx_start || rx_start);
	assign tx_take  = (state == S_TX) && (phase == PH_DATA) && (cnt[1:0] == 2'b00);
	assign rx_shift = (state == S_RX) && (phase == PH_DATA);

	//////////////////////////////////////////////////////////////////////
	// state machine

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= S_IDLE;
			cnt   <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					cnt <= '0;
					if (tx_start)
						state <= S_TX;
					else if (rx_start)
						state <= S_RX_WAIT;
				end
				S_RX_WAIT:
				begin
					cnt <= '0;
					if (start_seen)
						state <= S_RX;
				end
				S_TX, S_RX:
				begin
					if (cnt == CNT_W'(LAST))
						state <= S_IDLE;
					cnt <= cnt + 1'b1;
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// tx end bit reaches the pin a cycle after its phase
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			tx_end_d <= 1'b0;
			tx_done  <= 1'b0;
			rx_done  <= 1'b0;
		end
		else
		begin
			tx_end_d <= (state == S_TX) && (phase == PH_END);
			tx_done  <= tx_end_d;
			rx_done  <= (state == S_RX) && (phase == PH_END);
		end
	end

	a_one_start : assert property (@(posedge clk) disable iff (rst)
		!(tx_start && rx_start));

endmodule

//--- rtl/sd_byte_port.sv
// byte side of the dat bus
module sd_byte_port
#(
	parameter int BLOCK_BYTES = 8,
	parameter int RD_DEPTH    = 16
)
(
	input  logic          clk,
	input  logic          rst,
	input  logic          wr_valid,
	input  sd_pkg::byte_t wr_byte,
	output logic          wr_credit,
	input  logic          tx_take,
	input  logic          tx_start,
	input  logic          rx_shift,
	input  logic          rx_start,
	input  logic          rx_done,
	output sd_pkg::pair_t tx_pair,
	input  sd_pkg::pair_t rx_pair,
	input  sd_pkg::pair_t line_err,
	output logic          rd_valid,
	output sd_pkg::byte_t rd_byte,
	input  logic          rd_credit,
	output logic          rd_room,
	output logic          tx_error,
	output logic          rx_crc_error
);
	import sd_pkg::*;

	localparam int RD_W = $clog2(RD_DEPTH + 1);

	byte_t            wr_mem [2];
	logic             wr_wp;
	logic             wr_rp;
	logic [1:0]       wr_cnt;
	logic             wr_empty;
	byte_t            head;
	byte_t            tx_sh;
	logic             rx_shift_d;
	logic [1:0]       rx_pcnt;
	logic [5:0]       rx_acc;
	logic [RD_W-1:0]  rd_cnt;
	logic             err_q;

	//////////////////////////////////////////////////////////////////////
	// write path

	assign wr_empty = (wr_cnt == 2'd0);
	assign head     = wr_mem[wr_rp];

	// on a take the new byte's top pair goes straight to the lines
	assign tx_pair = tx_take ? (wr_empty ? 2'b11 : head[7:6]) : tx_sh[7:6];

	always_ff @(posedge clk)
	begin
		if (wr_valid)
			wr_mem[wr_wp] <= wr_byte;
		if (tx_take)
			tx_sh <= wr_empty ? 8'hff : {head[5:0], 2'b11};   // underrun sends ones
		else
			tx_sh <= {tx_sh[5:0], 2'b11};
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			wr_wp     <= 1'b0;
			wr_rp     <= 1'b0;
			wr_cnt    <= 2'd0;
			wr_credit <= 1'b0;
			tx_error  <= 1'b0;
		end
		else
		begin
			if (wr_valid)
				wr_wp <= ~wr_wp;
			if (tx_take && !wr_empty)
				wr_rp <= ~wr_rp;
			wr_cnt    <= wr_cnt + 2'(wr_valid) - 2'(tx_take && !wr_empty);
			wr_credit <= tx_take && !wr_empty;   // slot freed
			if (tx_start)
				tx_error <= 1'b0;
			else if (tx_take && wr_empty)
				tx_error <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read path, line bits land one cycle after the shift strobe

	assign rd_valid = rx_shift_d && (rx_pcnt == 2'd3);
	assign rd_byte  = {rx_acc, rx_pair};
	assign rd_room  = int'(rd_cnt) >= BLOCK_BYTES;

	// error seen on the done cycle itself, then held
	assign rx_crc_error = rx_done ? |line_err : err_q;

	always_ff @(posedge clk)
	begin
		if (rx_shift_d)
			rx_acc <= {rx_acc[3:0], rx_pair};
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			rx_shift_d <= 1'b0;
			rx_pcnt    <= 2'd0;
			rd_cnt     <= RD_W'(RD_DEPTH);
			err_q      <= 1'b0;
		end
		else
		begin
			rx_shift_d <= rx_shift;
			if (rx_start)
				rx_pcnt <= 2'd0;
			else if (rx_shift_d)
				rx_pcnt <= rx_pcnt + 2'd1;
			rd_cnt <= rd_cnt + RD_W'(rd_credit) - RD_W'(rd_valid);
			if (rx_start)
				err_q <= 1'b0;
			else if (rx_done)
				err_q <= |line_err;
		end
	end

	// source only writes with a credit in hand
	a_wr_not_full : assert property (@(posedge clk) disable iff (rst)
		wr_valid |-> (wr_cnt != 2'd2));

	// a block starts only with room for all of it
	a_rd_credit : assert property (@(posedge clk) disable iff (rst)
		rd_valid |-> (rd_cnt != '0));

endmodule

//--- rtl/sd_dat_bus.sv
// two line sd dat bus
module sd_dat_bus
#(
	parameter int BLOCK_BYTES = 8,
	parameter int RD_DEPTH    = 16
)
(
	input  logic          clk,
	input  logic          rst,
	input  logic          wr_valid,
	input  sd_pkg::byte_t wr_byte,
	output logic          wr_credit,
	output logic          rd_valid,
	output sd_pkg::byte_t rd_byte,
	input  logic          rd_credit,
	input  logic          tx_start,
	input  logic          rx_start,
	output logic          tx_done,
	output logic          rx_done,
	output logic          tx_error,
	output logic          rx_crc_error,
	output sd_pkg::pair_t dat_out,
	output sd_pkg::pair_t dat_oe,
	input  sd_pkg::pair_t dat_in
);
	import sd_pkg::*;

	line_phase_t phase;
	logic        rx_mode;
	logic        crc_clr;
	logic        tx_take;
	logic        rx_shift;
	logic        rd_room;
	pair_t       tx_pair;
	pair_t       rx_pair;
	pair_t       line_err;

	sd_dat_sequencer #(.BLOCK_BYTES(BLOCK_BYTES)) i_seq
	(
		.clk      (clk),
		.rst      (rst),
		.tx_start (tx_start),
		.rx_start (rx_start),
		.dat_in   (dat_in),
		.rd_room  (rd_room),
		.phase    (phase),
		.rx_mode  (rx_mode),
		.crc_clr  (crc_clr),
		.tx_take  (tx_take),
		.rx_shift (rx_shift),
		.tx_done  (tx_done),
		.rx_done  (rx_done)
	);

	// line 0 carries the even bits of each byte
	sd_dat_line i_line0
	(
		.clk     (clk),
		.rst     (rst),
		.phase   (phase),
		.tx      (tx_pair[0]),
		.rx_mode (rx_mode),
		.crc_clr (crc_clr),
		.dat_in  (dat_in[0]),
		.dat_out (dat_out[0]),
		.dat_oe  (dat_oe[0]),
		.rx_bit  (rx_pair[0]),
		.error   (line_err[0])
	);

	sd_dat_line i_line1
	(
		.clk     (clk),
		.rst     (rst),
		.phase   (phase),
		.tx      (tx_pair[1]),
		.rx_mode (rx_mode),
		.crc_clr (crc_clr),
		.dat_in  (dat_in[1]),
		.dat_out (dat_out[1]),
		.dat_oe  (dat_oe[1]),
		.rx_bit  (rx_pair[1]),
		.error   (line_err[1])
	);

	sd_byte_port #(.BLOCK_BYTES(BLOCK_BYTES), .RD_DEPTH(RD_DEPTH)) i_port
	(
		.clk          (clk),
		.rst          (rst),
		.wr_valid     (wr_valid),
		.wr_byte      (wr_byte),
		.wr_credit    (wr_credit),
		.tx_take      (tx_take),
		.tx_start     (tx_start),
		.rx_shift     (rx_shift),
		.rx_start     (rx_start),
		.rx_done      (rx_done),
		.tx_pair      (tx_pair),
		.rx_pair      (rx_pair),
		.line_err     (line_err),
		.rd_valid     (rd_valid),
		.rd_byte      (rd_byte),
		.rd_credit    (rd_credit),
		.rd_room      (rd_room),
		.tx_error     (tx_error),
		.rx_crc_error (rx_crc_error)
	);

endmodule

//--- tb/tb_sd_dat_bus.sv
// sd dat bus testbench
module tb_sd_dat_bus;
	timeunit 1ns;
	timeprecision 1ps;

	import sd_pkg::*;

	localparam int BLOCK_BYTES = 8;
	localparam int RD_DEPTH    = 16;
	localparam int NDATA       = 4 * BLOCK_BYTES;   // data bit times per line
	localparam int FRAME_LEN   = NDATA + 18;        // start, data, 16 crc, end
	// eight blocks of about 55 cycles, the idle waits, and a wide margin
	localparam int TIMEOUT     = 2000;

	logic  clk = 1'b0;
	logic  rst;
	logic  wr_valid;
	byte_t wr_byte;
	logic  wr_credit;
	logic  rd_valid;
	byte_t rd_byte;
	logic  rd_credit;
	logic  tx_start;
	logic  rx_start;
	logic  tx_done;
	logic  rx_done;
	logic  tx_error;
	logic  rx_crc_error;
	pair_t dat_out;
	pair_t dat_oe;
	pair_t dat_in;

	int                   seed   = 37160;
	int                   cycles = 0;
	byte_t                blk [BLOCK_BYTES];   // bytes of the current block
	logic [FRAME_LEN-1:0] frame0;              // line 0 frame, first bit at the top
	logic [FRAME_LEN-1:0] frame1;

	sd_dat_bus #(.BLOCK_BYTES(BLOCK_BYTES), .RD_DEPTH(RD_DEPTH)) i_dut
	(
		.clk          (clk),
		.rst          (rst),
		.wr_valid     (wr_valid),
		.wr_byte      (wr_byte),
		.wr_credit    (wr_credit),
		.rd_valid     (rd_valid),
		.rd_byte      (rd_byte),
		.rd_credit    (rd_credit),
		.tx_start     (tx_start),
		.rx_start     (rx_start),
		.tx_done      (tx_done),
		.rx_done      (rx_done),
		.tx_error     (tx_error),
		.rx_crc_error (rx_crc_error),
		.dat_out      (dat_out),
		.dat_oe       (dat_oe),
		.dat_in       (dat_in)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > TIMEOUT)
			abort_run("timeout, the tests did not finish within the cycle limit");
	end

	//////////////////////////////////////////////////////////////////////
	// checks

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		if (act !== exp)
			abort_run($sformatf("mismatch at %0d ns: %s expected %h, got %h",
				$time, name, exp, act));
	endtask

	task automatic check_pair(input string name, input pair_t exp, input pair_t act);
		if (act !== exp)
			abort_run($sformatf("mismatch at %0d ns: %s expected %b, got %b",
				$time, name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("mismatch at %0d ns: %s expected %b, got %b",
				$time, name, exp, act));
	endtask

	//////////////////////////////////////////////////////////////////////
	// card model and frame reference

	// x^16 + x^12 + x^5 + 1, seed zero, first bit at the top
	function automatic crc_t crc16(input logic [NDATA-1:0] bits);
		crc_t c;
		logic fb;
		c = '0;
		for (int i = NDATA - 1; i >= 0; i--)
		begin
			fb = c[15] ^ bits[i];
			c  = {c[14:0], 1'b0};
			if (fb)
				c = c ^ 16'h1021;
		end
		return c;
	endfunction

	// line 1 takes bits 7 5 3 1 of each byte, line 0 takes 6 4 2 0
	function automatic logic [NDATA-1:0] line_bits(input int line);
		logic [NDATA-1:0] v;
		for (int i = 0; i < BLOCK_BYTES; i++)
			for (int j = 0; j < 4; j++)
				v[NDATA - 1 - 4 * i - j] = blk[i][6 - 2 * j + line];
		return v;
	endfunction

	function automatic logic [FRAME_LEN-1:0] make_frame(input int line);
		logic [NDATA-1:0] d;
		d = line_bits(line);
		return {1'b0, d, crc16(d), 1'b1};
	endfunction

	// bytes past n_valid are never supplied and go out as ones
	task automatic new_block(input int n_valid);
		for (int i = 0; i < BLOCK_BYTES; i++)
			blk[i] = (i < n_valid) ? byte_t'($random(seed)) : 8'hff;
		frame0 = make_frame(0);
		frame1 = make_frame(1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// block level drivers

	task automatic send_block(input int n_supply);
		int   credits;
		int   sent;
		int   returned;
		int   pos;
		logic finished;
		credits  = 2;      // write buffer depth
		sent     = 0;
		returned = 0;
		pos      = 0;
		finished = 1'b0;
		new_block(n_supply);
		while (sent < n_supply && credits > 0)
		begin
			@(posedge clk);
			wr_valid <= 1'b1;
			wr_byte  <= blk[sent];
			sent++;
			credits--;
		end
		@(posedge clk);
		wr_valid <= 1'b0;
		tx_start <= 1'b1;
		@(posedge clk);
		tx_start <= 1'b0;
		while (!finished)
		begin
			@(negedge clk);
			if (wr_credit)
			begin
				returned++;
				credits++;
			end
			if (pos < FRAME_LEN)
			begin
				check_pair("dat_oe", 2'b11, dat_oe);
				check_pair("dat_out", {frame1[FRAME_LEN-1-pos], frame0[FRAME_LEN-1-pos]},
					dat_out);
				check_flag("tx_done", 1'b0, tx_done);
				pos++;
			end
			else
			begin
				check_pair("dat_oe", 2'b00, dat_oe);   // driver released after the end bit
				check_flag("tx_done", 1'b1, tx_done);
				check_flag("tx_error", n_supply < BLOCK_BYTES, tx_error);
				finished = 1'b1;
			end
			@(posedge clk);
			if (sent < n_supply && credits > 0)
			begin
				wr_valid <= 1'b1;
				wr_byte  <= blk[sent];
				sent++;
				credits--;
			end
			else
				wr_valid <= 1'b0;
		end
		if (returned != n_supply)
			abort_run($sformatf("expected %0d wr_credit pulses but counted %0d",
				n_supply, returned));
	endtask

	// corrupt 1 flips a crc bit on line 1, corrupt 2 clears the end bit of line 0
	task automatic receive_block(input int corrupt, input int lead, input logic give_credit,
		input logic issue_start);
		int   pos;
		int   got;
		logic pend;
		logic finished;
		pos      = 0;
		got      = 0;
		pend     = 1'b0;
		finished = 1'b0;
		new_block(BLOCK_BYTES);
		if (corrupt == 1)
			frame1[10] = ~frame1[10];
		else if (corrupt == 2)
			frame0[0] = 1'b0;
		if (issue_start)
		begin
			@(posedge clk);
			rx_start <= 1'b1;
			@(posedge clk);
			rx_start <= 1'b0;
		end
		repeat (lead) @(posedge clk);   // card latency before its start bit
		while (!finished)
		begin
			@(posedge clk);
			rd_credit <= pend;
			pend = 1'b0;
			if (pos < FRAME_LEN)
			begin
				dat_in <= {frame1[FRAME_LEN-1-pos], frame0[FRAME_LEN-1-pos]};
				pos++;
			end
			else
				dat_in <= 2'b11;
			@(negedge clk);
			if (rd_valid)
			begin
				if (got >= BLOCK_BYTES)
					abort_run("rd_valid seen after the last byte of the block");
				else
				begin
					check_byte("rd_byte", blk[got], rd_byte);
					got++;
					pend = give_credit;
				end
			end
			if (rx_done)
			begin
				check_flag("rx_crc_error", corrupt != 0, rx_crc_error);
				finished = 1'b1;
			end
		end
		if (got != BLOCK_BYTES)
			abort_run($sformatf("received %0d bytes, the block has %0d", got, BLOCK_BYTES));
		@(negedge clk);
		check_flag("rx_crc_error", corrupt != 0, rx_crc_error);   // status holds after done
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests

	task automatic idle_after_reset();
		repeat (8)
		begin
			@(negedge clk);
			check_pair("dat_oe", 2'b00, dat_oe);
			check_flag("wr_credit", 1'b0, wr_credit);
			check_flag("rd_valid", 1'b0, rd_valid);
			check_flag("tx_done", 1'b0, tx_done);
			check_flag("rx_done", 1'b0, rx_done);
		end
	endtask

	task automatic transmit_block();
		send_block(BLOCK_BYTES);
	endtask

	task automatic receive_good();
		receive_block(0, 1, 1'b1, 1'b1);
	endtask

	task automatic receive_corrupt();
		receive_block(1, 3, 1'b1, 1'b1);
		receive_block(2, 0, 1'b1, 1'b1);
	endtask

	// two blocks with no credit back leave the reader without room
	task automatic receive_backpressure();
		receive_block(0, 2, 1'b0, 1'b1);
		receive_block(0, 2, 1'b0, 1'b1);
		@(posedge clk);
		rx_start <= 1'b1;
		@(posedge clk);
		rx_start <= 1'b0;
		dat_in   <= 2'b00;   // card offers a start bit the reader has no room for
		repeat (20)
		begin
			@(negedge clk);
			check_flag("rd_valid", 1'b0, rd_valid);
			check_flag("rx_done", 1'b0, rx_done);
		end
		@(posedge clk);
		dat_in <= 2'b11;   // card backs off and sends the block again later
		repeat (2 * BLOCK_BYTES)
		begin
			@(posedge clk);
			rd_credit <= 1'b1;
		end
		receive_block(0, 0, 1'b1, 1'b0);   // sequencer is still waiting for a start bit
	endtask

	// only the first byte is supplied, the rest must go out as all ones
	task automatic transmit_underrun();
		send_block(1);
	endtask

	initial
	begin
		rst       = 1'b1;
		wr_valid  = 1'b0;
		wr_byte   = '0;
		rd_credit = 1'b0;
		tx_start  = 1'b0;
		rx_start  = 1'b0;
		dat_in    = 2'b11;   // idle bus level
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		idle_after_reset();
		transmit_block();
		receive_good();
		receive_corrupt();
		receive_backpressure();
		transmit_underrun();
		$display("No errors");
		$finish;
	end

endmodule

//--- verilog.f
rtl/sd_pkg.sv
rtl/sd_crc16.sv
rtl/sd_dat_line.sv
rtl/sd_dat_sequencer.sv
rtl/sd_byte_port.sv
rtl/sd_dat_bus.sv
tb/tb_sd_dat_bus.sv

//--- Makefile
TOP = tb_sd_dat_bus

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and pass if the log reports no errors"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		-f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
